// ==== tb.f ====
+incdir+logic
logic/pipe_pkg.sv
logic/bus_pkg.sv
logic/mem_stage.sv
logic/dcache.sv
logic/write_queue.sv
logic/mem_unit.sv
bench/tb_clock.sv
bench/tb_bus_memory.sv
bench/tb_mem_unit.sv

// ==== run.sh ====
#!/bin/sh
# Compile the memory unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mem_unit -Mdir obj_dir -f tb.f
./obj_dir/Vtb_mem_unit

// ==== bench/tb_mem_unit.sv ====
/*
 Testbench for the memory unit. Sends random loads, stores, flushes and
 pass-through requests, checks every result against a reference model and
 compares memory contents and cache counters at the end.
*/
`timescale 1ns/1ps
`include "lsu_consts.svh"

module tb_mem_unit;
	import pipe_pkg::*;
	import bus_pkg::*;

	localparam int NUM_REQUESTS = 400;
	localparam int WATCHDOG_NS = NUM_REQUESTS * 40 * 20;
	localparam logic [31:0] SEED = 32'hc4be_af60;
	localparam bus_addr_t CACHED_BASE = {`CACHEABLE_REGION, 28'h0};
	localparam bus_addr_t UNCACHED_BASE = 32'h2000_0000;

	logic clock;
	logic reset;
	logic req_valid;
	exec_req_t req;
	logic req_ready;
	logic res_valid;
	mem_result_t res;
	logic res_ready;
	logic bus_rw;
	logic bus_request;
	logic bus_ready;
	bus_addr_t bus_address;
	bus_word_t bus_rdata;
	bus_word_t bus_wdata;
	logic [`COUNTER_BITS-1:0] dcache_hit;
	logic [`COUNTER_BITS-1:0] dcache_miss;
	logic [`COUNTER_BITS-1:0] bus_reads;

	// ==============================
	// Reference model state

	bus_word_t shadow [1024];
	logic [`DCACHE_LINES-1:0] line_valid;
	logic [31:0] line_tag [`DCACHE_LINES];
	logic [`COUNTER_BITS-1:0] model_hits;
	logic [`COUNTER_BITS-1:0] model_misses;
	logic [`COUNTER_BITS-1:0] uncached_reads;
	mem_result_t expected_q [$];
	int results_seen;
	logic [31:0] rand_state;
	bus_addr_t last_store;

	tb_clock u_clock (
		.o_clock(clock),
		.o_reset(reset)
	);

	mem_unit u_mem_unit (
		.i_clock(clock),
		.i_reset(reset),
		.i_req_valid(req_valid),
		.i_req(req),
		.o_req_ready(req_ready),
		.o_res_valid(res_valid),
		.o_res(res),
		.i_res_ready(res_ready),
		.o_bus_rw(bus_rw),
		.o_bus_request(bus_request),
		.i_bus_ready(bus_ready),
		.o_bus_address(bus_address),
		.i_bus_rdata(bus_rdata),
		.o_bus_wdata(bus_wdata),
		.o_dcache_hit(dcache_hit),
		.o_dcache_miss(dcache_miss)
	);

	tb_bus_memory u_bus_memory (
		.i_clock(clock),
		.i_reset(reset),
		.i_request(bus_request),
		.i_rw(bus_rw),
		.i_address(bus_address),
		.i_wdata(bus_wdata),
		.o_ready(bus_ready),
		.o_rdata(bus_rdata),
		.o_read_count(bus_reads)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function logic [31:0] next_random();
		rand_state = lcg_step(rand_state);
		return rand_state;
	endfunction

	function automatic logic [9:0] word_slot(input bus_addr_t a);
		return {a[31:28] != `CACHEABLE_REGION, a[10:2]};
	endfunction

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic check_result(input mem_result_t got, input mem_result_t want);
		if (got !== want)
			stop_with_failure($sformatf(
				"MISMATCH o_res: got pc=%h rd_value=%h rd_index=%h, expected pc=%h rd_value=%h rd_index=%h",
				got.pc, got.rd_value, got.rd_index, want.pc, want.rd_value, want.rd_index));
	endtask

	task automatic check_count(input string name, input logic [`COUNTER_BITS-1:0] got,
			input logic [`COUNTER_BITS-1:0] want);
		if (got !== want)
			stop_with_failure($sformatf("MISMATCH %s: got %h, expected %h", name, got, want));
	endtask

	task automatic check_word(input string name, input bus_word_t got, input bus_word_t want);
		if (got !== want)
			stop_with_failure($sformatf("MISMATCH %s: got %h, expected %h", name, got, want));
	endtask

	// ==============================
	// Model of the cache tags and counters

	task automatic model_read(input bus_addr_t a);
		logic [31:0] word;
		logic [31:0] tag;
		int line;
		word = a >> 2;
		line = int'(word % `DCACHE_LINES);
		tag = word / `DCACHE_LINES;
		if (a[31:28] != `CACHEABLE_REGION) begin
			uncached_reads += 1;
		end else if (line_valid[line] && line_tag[line] == tag) begin
			model_hits += 1;
		end else begin
			model_misses += 1;
			line_valid[line] = 1'b1;
			line_tag[line] = tag;
		end
	endtask

	function automatic bus_word_t load_value(input bus_word_t w, input exec_req_t r);
		int lane;
		logic [7:0] b;
		logic [15:0] h;
		lane = int'(r.address[1:0]);
		b = w[lane * 8 +: 8];
		h = w[(lane / 2) * 16 +: 16];
		case (r.width)
			W_BYTE: return {{24{r.is_signed & b[7]}}, b};
			W_HALF: return {{16{r.is_signed & h[15]}}, h};
			default: return w;
		endcase
	endfunction

	// Write hits keep their tag, so only the shadow word changes
	task automatic apply_store(input exec_req_t r);
		int slot;
		int lane;
		int n;
		slot = int'(word_slot(r.address));
		lane = int'(r.address[1:0]);
		n = (r.width == W_BYTE) ? 1 : (r.width == W_HALF) ? 2 : 4;
		if (n < 4)
			model_read(r.address);
		for (int b = 0; b < n; b++)
			shadow[slot][(lane + b) * 8 +: 8] = r.data[b * 8 +: 8];
		last_store = r.address;
	endtask

	task automatic build_request(output exec_req_t r);
		logic [31:0] pick;
		logic [31:0] where;
		int kind;
		bus_addr_t base;
		pick = next_random();
		where = next_random();
		r.pc = next_random() & 32'hffff_fffc;
		r.data = next_random();
		r.rd_index = pick[4:0];
		r.is_signed = pick[5];
		kind = int'(pick[31:16] % 16'd100);
		if (kind < 30)
			r.op = OP_LOAD;
		else if (kind < 65)
			r.op = OP_STORE;
		else if (kind < 90)
			r.op = OP_NONE;
		else
			r.op = OP_FLUSH;
		case (pick[15:8] % 8'd3)
			8'd0: r.width = W_BYTE;
			8'd1: r.width = W_HALF;
			default: r.width = W_WORD;
		endcase
		// 64 words per window give a mix of hits, misses and conflicts
		base = where[31] ? UNCACHED_BASE : CACHED_BASE;
		r.address = base | {24'h0, where[21:16], 2'b00};
		if (r.op == OP_LOAD && where[30])
			r.address = {last_store[31:2], 2'b00};
		case (r.width)
			W_BYTE: r.address[1:0] = where[1:0];
			W_HALF: r.address[1:0] = {where[1], 1'b0};
			default: r.address[1:0] = 2'b00;
		endcase
	endtask

	// Called on a falling edge, returns on the falling edge after the transfer
	task automatic send_request(input exec_req_t r);
		req = r;
		req_valid = 1'b1;
		while (!req_ready)
			@(negedge clock);
		@(negedge clock);
		req_valid = 1'b0;
	endtask

	// ==============================
	// Stimulus and final checks

	initial begin
		exec_req_t r;
		mem_result_t want;
		int idle;
		req_valid = 1'b0;
		req = '0;
		rand_state = SEED;
		line_valid = '0;
		model_hits = '0;
		model_misses = '0;
		uncached_reads = '0;
		results_seen = 0;
		last_store = CACHED_BASE;
		@(negedge clock);
		while (reset)
			@(negedge clock);
		for (int k = 0; k < 1024; k++)
			shadow[k] = u_bus_memory.mem[k];

		for (int n = 0; n < NUM_REQUESTS; n++) begin
			build_request(r);
			want.pc = r.pc;
			want.rd_value = r.data;
			want.rd_index = r.rd_index;
			case (r.op)
				OP_LOAD: begin
					model_read(r.address);
					want.rd_value = load_value(shadow[word_slot(r.address)], r);
				end
				OP_STORE: apply_store(r);
				OP_FLUSH: line_valid = '0;
				default: ;
			endcase
			expected_q.push_back(want);
			send_request(r);
		end

		while (results_seen < NUM_REQUESTS)
			@(negedge clock);
		// Queue has drained once the bus stays quiet
		idle = 0;
		while (idle < 4) begin
			@(negedge clock);
			if (bus_request)
				idle = 0;
			else
				idle++;
		end

		for (int k = 0; k < 1024; k++)
			check_word($sformatf("bus memory word %0d", k), u_bus_memory.mem[k], shadow[k]);
		check_count("o_dcache_hit", dcache_hit, model_hits);
		check_count("o_dcache_miss", dcache_miss, model_misses);
		check_count("bus read count", bus_reads, model_misses + uncached_reads);
		$display("TEST RESULT: PASS");
		$finish;
	end

	// Result side with random writeback stalls
	initial begin
		logic [31:0] ready_state;
		ready_state = lcg_step(SEED);
		res_ready = 1'b0;
		forever begin
			@(negedge clock);
			ready_state = lcg_step(ready_state);
			res_ready = !reset && (ready_state[31:24] >= 8'd102);
			if (res_valid && res_ready) begin
				if (expected_q.size() == 0) begin
					stop_with_failure("A result came out with no request outstanding");
				end else begin
					check_result(res, expected_q.pop_front());
					results_seen++;
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		stop_with_failure("Watchdog expired before all results came back");
	end

endmodule

// ==== bench/tb_bus_memory.sv ====
/*
 Bus slave memory for the testbench. Two 2 KB windows, one cacheable and one
 not, answer each access after a random delay and count the reads served.
 Outputs change on the falling clock edge.
*/
`timescale 1ns/1ps
`include "lsu_consts.svh"

module tb_bus_memory (
	input logic i_clock,
	input logic i_reset,
	input logic i_request,
	input logic i_rw,
	input bus_pkg::bus_addr_t i_address,
	input bus_pkg::bus_word_t i_wdata,
	output logic o_ready,
	output bus_pkg::bus_word_t o_rdata,
	output logic [`COUNTER_BITS-1:0] o_read_count
);
	import bus_pkg::*;

	bus_word_t mem [1024];
	logic [31:0] delay_state;
	logic busy;
	logic [1:0] wait_left;
	logic [9:0] slot;

	function automatic logic [31:0] step_lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Upper half of the array is the uncacheable window
	assign slot = {i_address[31:28] != `CACHEABLE_REGION, i_address[10:2]};

	initial begin
		bus_addr_t a;
		o_ready = 1'b0;
		o_rdata = '0;
		o_read_count = '0;
		busy = 1'b0;
		wait_left = 2'd0;
		delay_state = 32'hc4be_af60;
		for (int k = 0; k < 1024; k++) begin
			a = {(k >= 512) ? 4'h2 : `CACHEABLE_REGION, 17'h0, k[8:0], 2'b00};
			mem[k] = (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
		end
	end

	always @(negedge i_clock) begin
		if (i_reset) begin
			o_ready <= 1'b0;
			busy <= 1'b0;
			o_read_count <= '0;
		end else if (o_ready) begin
			o_ready <= 1'b0;
		end else if (busy) begin
			if (wait_left == 2'd0) begin
				busy <= 1'b0;
				o_ready <= 1'b1;
				if (i_rw) begin
					mem[slot] <= i_wdata;
				end else begin
					o_rdata <= mem[slot];
					o_read_count <= o_read_count + 1'b1;
				end
			end else begin
				wait_left <= wait_left - 1'b1;
			end
		end else if (i_request) begin
			// Extra wait of 0 to 3 cycles
			delay_state <= step_lcg(delay_state);
			wait_left <= delay_state[29:28];
			busy <= 1'b1;
		end
	end

endmodule

// ==== bench/tb_clock.sv ====
/*
 Clock and reset source for the testbench.
 Runs a 20 ns clock and holds reset for the first two cycles.
*/
`timescale 1ns/1ps

module tb_clock (
	output logic o_clock,
	output logic o_reset
);
	initial begin
		o_clock = 1'b0;
		forever #10 o_clock = ~o_clock;
	end

	initial begin
		o_reset = 1'b1;
		repeat (2) @(posedge o_clock);
		o_reset <= 1'b0;
	end

endmodule

// ==== logic/mem_unit.sv ====
/*
 Memory unit top. Joins the memory stage, the data cache and the write queue
 and exposes the pipeline handshakes, the bus and the cache counters.
*/
`timescale 1ns/1ps
`include "lsu_consts.svh"

module mem_unit (
	input logic i_clock,
	input logic i_reset,

	input logic i_req_valid,
	input pipe_pkg::exec_req_t i_req,
	output logic o_req_ready,
	output logic o_res_valid,
	output pipe_pkg::mem_result_t o_res,
	input logic i_res_ready,

	output logic o_bus_rw,
	output logic o_bus_request,
	input logic i_bus_ready,
	output bus_pkg::bus_addr_t o_bus_address,
	input bus_pkg::bus_word_t i_bus_rdata,
	output bus_pkg::bus_word_t o_bus_wdata,

	output logic [`COUNTER_BITS-1:0] o_dcache_hit,
	output logic [`COUNTER_BITS-1:0] o_dcache_miss
);
	import bus_pkg::*;

	// Stage to cache
	logic cache_request;
	cache_op_t cache_op;
	bus_addr_t cache_address;
	bus_word_t cache_wdata;
	logic cache_ready;
	bus_word_t cache_rdata;

	// Cache to write queue
	logic wq_request;
	logic wq_rw;
	bus_addr_t wq_address;
	bus_word_t wq_wdata;
	logic wq_ready;
	bus_word_t wq_rdata;

	mem_stage u_mem_stage (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_req_valid(i_req_valid),
		.i_req(i_req),
		.o_req_ready(o_req_ready),
		.o_res_valid(o_res_valid),
		.o_res(o_res),
		.i_res_ready(i_res_ready),
		.o_cache_request(cache_request),
		.o_cache_op(cache_op),
		.o_cache_address(cache_address),
		.o_cache_wdata(cache_wdata),
		.i_cache_ready(cache_ready),
		.i_cache_rdata(cache_rdata)
	);

	dcache u_dcache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(cache_request),
		.i_op(cache_op),
		.i_address(cache_address),
		.i_wdata(cache_wdata),
		.o_ready(cache_ready),
		.o_rdata(cache_rdata),
		.o_bus_request(wq_request),
		.o_bus_rw(wq_rw),
		.o_bus_address(wq_address),
		.o_bus_wdata(wq_wdata),
		.i_bus_ready(wq_ready),
		.i_bus_rdata(wq_rdata),
		.o_hit(o_dcache_hit),
		.o_miss(o_dcache_miss)
	);

	write_queue u_write_queue (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(wq_request),
		.i_rw(wq_rw),
		.i_address(wq_address),
		.i_wdata(wq_wdata),
		.o_ready(wq_ready),
		.o_rdata(wq_rdata),
		.o_bus_request(o_bus_request),
		.o_bus_rw(o_bus_rw),
		.o_bus_address(o_bus_address),
		.o_bus_wdata(o_bus_wdata),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

endmodule

// ==== logic/write_queue.sv ====
/*
 Posted write FIFO between the data cache and the bus.
 Writes are acknowledged on entry and drain in order, reads go out only
 once every older write has reached the bus.
*/
`timescale 1ns/1ps
`include "lsu_consts.svh"

module write_queue (
	input logic i_clock,
	input logic i_reset,

	// Cache side
	input logic i_request,
	input logic i_rw,
	input bus_pkg::bus_addr_t i_address,
	input bus_pkg::bus_word_t i_wdata,
	output logic o_ready,
	output bus_pkg::bus_word_t o_rdata,

	// Bus side
	output logic o_bus_request,
	output logic o_bus_rw,
	output bus_pkg::bus_addr_t o_bus_address,
	output bus_pkg::bus_word_t o_bus_wdata,
	input logic i_bus_ready,
	input bus_pkg::bus_word_t i_bus_rdata
);
	import bus_pkg::*;

	localparam int PTR_BITS = $clog2(`WQ_DEPTH);

	bus_addr_t addr_mem [`WQ_DEPTH];
	bus_word_t data_mem [`WQ_DEPTH];
	logic [PTR_BITS-1:0] head;
	logic [PTR_BITS-1:0] tail;
	logic [PTR_BITS:0] count;
	logic full;
	logic empty;
	logic bus_done;
	logic push;
	logic pop;
	logic drain;
	logic read_go;

	assign full = (count == (PTR_BITS+1)'(`WQ_DEPTH));
	assign empty = (count == '0);
	assign bus_done = o_bus_request && i_bus_ready;
	assign push = i_request && i_rw && !o_ready && !full;
	assign pop = bus_done && o_bus_rw;
	assign drain = !o_bus_request && !empty;
	assign read_go = i_request && !i_rw && !o_ready && !o_bus_request && empty;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			o_ready <= 1'b0;
			o_bus_request <= 1'b0;
		end else begin
			o_ready <= push || (bus_done && !o_bus_rw);
			if (push)
				tail <= tail + 1'b1;
			if (pop)
				head <= head + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
			if (drain || read_go)
				o_bus_request <= 1'b1;
			else if (bus_done)
				o_bus_request <= 1'b0;
		end
	end

	// Entries and bus payload
	always_ff @(posedge i_clock) begin
		if (push) begin
			addr_mem[tail] <= i_address;
			data_mem[tail] <= i_wdata;
		end
		if (drain) begin
			o_bus_rw <= 1'b1;
			o_bus_address <= addr_mem[head];
			o_bus_wdata <= data_mem[head];
		end else if (read_go) begin
			o_bus_rw <= 1'b0;
			o_bus_address <= i_address;
		end
		if (bus_done && !o_bus_rw)
			o_rdata <= i_bus_rdata;
	end

	// A write meeting a full FIFO gets no acknowledge
	assert property (@(posedge i_clock) disable iff (i_reset)
		i_request && i_rw && full |=> !o_ready);

endmodule

// ==== logic/dcache.sv ====
/*
 Direct mapped write-through data cache with read allocation.
 Serves the memory stage, forwards every write and every miss to the
 write queue below, and counts hits and misses of cacheable reads.
*/
`timescale 1ns/1ps
`include "lsu_consts.svh"

module dcache (
	input logic i_clock,
	input logic i_reset,

	// Memory stage side
	input logic i_request,
	input bus_pkg::cache_op_t i_op,
	input bus_pkg::bus_addr_t i_address,
	input bus_pkg::bus_word_t i_wdata,
	output logic o_ready,
	output bus_pkg::bus_word_t o_rdata,

	// Downstream side
	output logic o_bus_request,
	output logic o_bus_rw,
	output bus_pkg::bus_addr_t o_bus_address,
	output bus_pkg::bus_word_t o_bus_wdata,
	input logic i_bus_ready,
	input bus_pkg::bus_word_t i_bus_rdata,

	output logic [`COUNTER_BITS-1:0] o_hit,
	output logic [`COUNTER_BITS-1:0] o_miss
);
	import bus_pkg::*;

	localparam int INDEX_BITS = $clog2(`DCACHE_LINES);
	localparam int TAG_BITS = 30 - INDEX_BITS;

	logic [`DCACHE_LINES-1:0] valid;
	logic [TAG_BITS-1:0] tag_mem [`DCACHE_LINES];
	bus_word_t data_mem [`DCACHE_LINES];

	logic [INDEX_BITS-1:0] index;
	logic [TAG_BITS-1:0] tag;
	logic cacheable;
	logic hit;
	logic start;
	logic bus_done;
	logic fill;

	assign index = i_address[INDEX_BITS+1:2];
	assign tag = i_address[31:INDEX_BITS+2];
	assign cacheable = (i_address[31:28] == `CACHEABLE_REGION);
	assign hit = cacheable && valid[index] && (tag_mem[index] == tag);

	// Stage request is held until the ready pulse, so ignore it while answering
	assign start = i_request && !o_ready && !o_bus_request;
	assign bus_done = o_bus_request && i_bus_ready;
	assign fill = bus_done && !o_bus_rw && cacheable;

	// ==============================
	// Control and counters

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_ready <= 1'b0;
			o_bus_request <= 1'b0;
			valid <= '0;
			o_hit <= '0;
			o_miss <= '0;
		end else begin
			o_ready <= 1'b0;
			if (start) begin
				case (i_op)
					C_FLUSH: begin
						valid <= '0;
						o_ready <= 1'b1;
					end
					C_READ: begin
						if (hit) begin
							o_ready <= 1'b1;
							o_hit <= o_hit + 1'b1;
						end else begin
							o_bus_request <= 1'b1;
							if (cacheable)
								o_miss <= o_miss + 1'b1;
						end
					end
					default: o_bus_request <= 1'b1;
				endcase
			end else if (bus_done) begin
				o_bus_request <= 1'b0;
				o_ready <= 1'b1;
				if (fill)
					valid[index] <= 1'b1;
			end
		end
	end

	// ==============================
	// Line array and downstream payload

	always_ff @(posedge i_clock) begin
		if (start) begin
			o_bus_rw <= (i_op == C_WRITE);
			o_bus_address <= i_address;
			o_bus_wdata <= i_wdata;
			o_rdata <= data_mem[index];
			if (i_op == C_WRITE && hit)
				data_mem[index] <= i_wdata;
		end else if (bus_done) begin
			o_rdata <= i_bus_rdata;
			if (fill) begin
				tag_mem[index] <= tag;
				data_mem[index] <= i_bus_rdata;
			end
		end
	end

	// Downstream answers only an access that is open
	assert property (@(posedge i_clock) disable iff (i_reset)
		i_bus_ready |-> o_bus_request);

	// A new access never rises while downstream is still answering
	assert property (@(posedge i_clock) disable iff (i_reset)
		$rose(o_bus_request) |-> !i_bus_ready);

endmodule

// ==== logic/mem_stage.sv ====
/*
 Memory stage control of the core.
 Takes one execute request at a time, runs loads, stores and flushes against
 the data cache and hands back one result per request in order.
*/
`timescale 1ns/1ps

module mem_stage (
	input logic i_clock,
	input logic i_reset,

	// Execute side
	input logic i_req_valid,
	input pipe_pkg::exec_req_t i_req,
	output logic o_req_ready,

	// Writeback side
	output logic o_res_valid,
	output pipe_pkg::mem_result_t o_res,
	input logic i_res_ready,

	// Data cache
	output logic o_cache_request,
	output bus_pkg::cache_op_t o_cache_op,
	output bus_pkg::bus_addr_t o_cache_address,
	output bus_pkg::bus_word_t o_cache_wdata,
	input logic i_cache_ready,
	input bus_pkg::bus_word_t i_cache_rdata
);
	import pipe_pkg::*;
	import bus_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		READ,
		WRITE_WORD,
		RMW_READ,
		RMW_WRITE,
		FLUSH,
		RESULT
	} state_t;

	state_t state;
	exec_req_t req_q;
	mem_result_t res_q;
	logic accept;
	logic [4:0] lane_shift;
	bus_word_t shifted;
	bus_word_t load_value;
	bus_word_t lane_mask;
	bus_word_t merged;

	assign o_req_ready = (state == IDLE);
	assign accept = i_req_valid && o_req_ready;
	assign o_res_valid = (state == RESULT);
	assign o_res = res_q;
	assign o_cache_address = {req_q.address[31:2], 2'b00};
	assign lane_shift = {req_q.address[1:0], 3'b000};

	// ==============================
	// Load extension

	always_comb begin
		shifted = i_cache_rdata >> lane_shift;
		case (req_q.width)
			W_BYTE: load_value = {{24{req_q.is_signed & shifted[7]}}, shifted[7:0]};
			W_HALF: load_value = {{16{req_q.is_signed & shifted[15]}}, shifted[15:0]};
			default: load_value = shifted;
		endcase
	end

	// New bytes into their lane of the old word
	always_comb begin
		if (req_q.width == W_BYTE)
			lane_mask = 32'h0000_00ff << lane_shift;
		else
			lane_mask = 32'h0000_ffff << lane_shift;
		merged = (i_cache_rdata & ~lane_mask) | ((req_q.data << lane_shift) & lane_mask);
	end

	// ==============================
	// Control FSM

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= IDLE;
			o_cache_request <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (accept) begin
						case (i_req.op)
							OP_LOAD: begin
								o_cache_request <= 1'b1;
								state <= READ;
							end
							OP_STORE: begin
								o_cache_request <= 1'b1;
								state <= (i_req.width == W_WORD) ? WRITE_WORD : RMW_READ;
							end
							OP_FLUSH: begin
								o_cache_request <= 1'b1;
								state <= FLUSH;
							end
							default: state <= RESULT;
						endcase
					end
				end
				READ, WRITE_WORD, FLUSH: begin
					if (i_cache_ready) begin
						o_cache_request <= 1'b0;
						state <= RESULT;
					end
				end
				RMW_READ: begin
					if (i_cache_ready) begin
						o_cache_request <= 1'b0;
						state <= RMW_WRITE;
					end
				end
				RMW_WRITE: begin
					// Request stays low one cycle between the two halves
					if (!o_cache_request) begin
						o_cache_request <= 1'b1;
					end else if (i_cache_ready) begin
						o_cache_request <= 1'b0;
						state <= RESULT;
					end
				end
				RESULT: begin
					if (i_res_ready)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Latched request, result and cache payload
	always_ff @(posedge i_clock) begin
		if (accept) begin
			req_q <= i_req;
			res_q.pc <= i_req.pc;
			res_q.rd_value <= i_req.data;
			res_q.rd_index <= i_req.rd_index;
			o_cache_wdata <= i_req.data;
			case (i_req.op)
				OP_STORE: o_cache_op <= (i_req.width == W_WORD) ? C_WRITE : C_READ;
				OP_FLUSH: o_cache_op <= C_FLUSH;
				default: o_cache_op <= C_READ;
			endcase
		end
		if (state == READ && i_cache_ready)
			res_q.rd_value <= load_value;
		if (state == RMW_READ && i_cache_ready) begin
			o_cache_op <= C_WRITE;
			o_cache_wdata <= merged;
		end
	end

	// Loads and stores are naturally aligned
	assert property (@(posedge i_clock) disable iff (i_reset)
		accept && (i_req.op == OP_LOAD || i_req.op == OP_STORE) |->
			(i_req.width == W_BYTE) ||
			(i_req.width == W_HALF && !i_req.address[0]) ||
			(i_req.width == W_WORD && i_req.address[1:0] == 2'b00));

endmodule

// ==== logic/bus_pkg.sv ====
/*
 Bus side types shared by the stage, the data cache, the write queue and the top.
*/
package bus_pkg;

	// Data word on every bus level
	typedef logic [31:0] bus_word_t;

	// Word aligned byte address
	typedef logic [31:0] bus_addr_t;

	// Access kinds from the stage to the data cache
	typedef enum logic [1:0] {
		C_READ,
		C_WRITE,
		C_FLUSH
	} cache_op_t;

endpackage

// ==== logic/pipe_pkg.sv ====
/*
 Pipeline side types of the memory stage.
 Requests come from execute, results go on to writeback.
*/
package pipe_pkg;

	// Kind of memory work carried by a request
	typedef enum logic [1:0] {
		OP_NONE,
		OP_LOAD,
		OP_STORE,
		OP_FLUSH
	} mem_op_t;

	typedef enum logic [1:0] {
		W_BYTE,
		W_HALF,
		W_WORD
	} mem_width_t;

	// Request from execute
	typedef struct packed {
		logic [31:0] pc;
		mem_op_t op;
		mem_width_t width;
		logic is_signed;
		logic [31:0] address;
		logic [31:0] data;	// store data or passed-through result
		logic [4:0] rd_index;
	} exec_req_t;

	// Result towards writeback
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] rd_value;
		logic [4:0] rd_index;
	} mem_result_t;

endpackage

// ==== logic/lsu_consts.svh ====
/*
 Build constants for the memory stage, data cache and write queue.
 Include this header wherever one of the sizes below is needed.
*/
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// ==============================
// Data cache

// One word per line, must be a power of two
`define DCACHE_LINES 16

// Address bits 31:28 of the cacheable region
`define CACHEABLE_REGION 4'h1

// Width of the hit and miss counters
`define COUNTER_BITS 32

// ==============================
// Write queue

// Posted write entries, must be a power of two
`define WQ_DEPTH 4

`endif
